//--- hw/img_pkg.sv
package img_pkg;

    // source image and result geometry

    typedef logic [7:0]  pixel_t;     // 8-bit grey level
    typedef logic [6:0]  coord_t;     // source row or column
    typedef logic [5:0]  tgt_t;       // target row or column index
    typedef logic [13:0] src_addr_t;  // row * 100 + column
    typedef logic [11:0] dst_addr_t;  // row * tw + column

    // one source row in memory
    localparam src_addr_t SRC_STRIDE = 14'd100;

endpackage

//--- hw/bic_pkg.sv
package bic_pkg;

    // fraction precision of the source position
    localparam int FRAC_BITS = 15;

    // tap fifo, also the number of credits the fetcher starts with
    localparam int FIFO_DEPTH = 4;
    localparam int PTR_W      = $clog2(FIFO_DEPTH);
    localparam int CREDIT_W   = $clog2(FIFO_DEPTH + 1);

    // kernel arithmetic
    localparam int COEF_W   = 13;                 // a..d in half units, about 3x a tap
    localparam int ACC_W    = 62;
    localparam int ACC_FRAC = 3 * FRAC_BITS + 1;  // x^3 bits plus the half-unit bit

    typedef logic [FRAC_BITS-1:0]     frac_t;
    typedef logic signed [9:0]        tap_t;      // pixel in half units
    typedef logic signed [COEF_W-1:0] coef_t;
    typedef logic signed [ACC_W-1:0]  acc_t;

    // everything the interpolator needs for one target pixel
    typedef struct packed {
        tap_t               p0;
        tap_t               p1;
        tap_t               p2;
        tap_t               p3;
        frac_t              frac;
        img_pkg::dst_addr_t addr;
        logic               last;   // final pixel of the run
    } tap_group_t;

endpackage

//--- hw/tap_link_if.sv
`timescale 1ns/1ps

interface tap_link_if;
    import bic_pkg::*;

    logic       push;
    tap_group_t push_group;
    logic       credit;      // one pulse per entry leaving the fifo
    logic       pop_valid;
    tap_group_t pop_group;

    // producer side
    modport fetch (
        output push,
        output push_group,
        input  credit
    );

    modport fifo (
        input  push,
        input  push_group,
        output credit,
        output pop_valid,
        output pop_group
    );

    // consumer takes every entry shown, so no ready
    modport interp (
        input  pop_valid,
        input  pop_group
    );

endinterface

//--- hw/tap_fetcher.sv
`timescale 1ns/1ps

module tap_fetcher (
    input  logic               CLK,
    input  logic               RST,
    input  logic               start,
    input  img_pkg::coord_t    v0,
    input  img_pkg::coord_t    h0,
    input  logic [4:0]         sw,
    input  img_pkg::tgt_t      sh,
    input  img_pkg::tgt_t      tw,
    output logic               src_rd,
    output img_pkg::src_addr_t src_addr,
    input  img_pkg::pixel_t    src_data,
    tap_link_if.fetch          link
);
    import img_pkg::*;
    import bic_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_SUB,     // remainder reduction, one step per cycle
        S_DIV,     // serial divide for the fraction
        S_READ,
        S_PUSH
    } state_t;

    state_t              state;
    coord_t              h0_q;
    logic [4:0]          sw_m1;
    tgt_t                sh_m1;
    tgt_t                tw_m1;
    tgt_t                row;
    tgt_t                col;
    src_addr_t           row_base;
    dst_addr_t           dst_cnt;
    logic [6:0]          rem;       // position remainder, in units of 1/(tw-1)
    coord_t              off;       // integer source offset within the row
    logic [6:0]          div_r;
    logic [3:0]          div_cnt;
    logic [7:0]          div_trial;
    frac_t               frac;
    logic [1:0]          rd_cnt;
    logic [1:0]          rd_idx;
    logic                rd_q;
    logic                single_q;
    logic                single;
    logic                last_col;
    logic                last_row;
    coord_t              rd_col;
    tap_t                taps [4];
    logic [CREDIT_W-1:0] credits;

    assign single   = (frac == '0);  // source pixel hit exactly
    assign last_col = (col == tw_m1);
    assign last_row = (row == sh_m1);

    // restoring step, msb set means the trial went negative
    assign div_trial = {div_r, 1'b0} - {2'b00, tw_m1};

    // p0..p3 sit at offset -1..+2, a single read uses the offset itself
    assign rd_col   = h0_q + off + coord_t'(rd_cnt) - coord_t'(!single);
    assign src_rd   = (state == S_READ);
    assign src_addr = row_base + src_addr_t'(rd_col);

    assign link.push = (state == S_PUSH) && !rd_q && (credits != '0);
    assign link.push_group = '{
        p0:   taps[0],
        p1:   taps[1],
        p2:   taps[2],
        p3:   taps[3],
        frac: frac,
        addr: dst_cnt,
        last: last_col && last_row
    };

    always_ff @(posedge CLK) begin
        if (RST) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: begin
                    if (start) begin
                        h0_q     <= h0;
                        sw_m1    <= sw - 5'd1;
                        sh_m1    <= sh - 6'd1;
                        tw_m1    <= tw - 6'd1;
                        row_base <= src_addr_t'(v0) * SRC_STRIDE;
                        row      <= '0;
                        col      <= '0;
                        rem      <= '0;
                        off      <= '0;
                        dst_cnt  <= '0;
                        div_r    <= '0;
                        div_cnt  <= '0;
                        state    <= S_DIV;
                    end
                end
                S_SUB: begin
                    if (rem >= {1'b0, tw_m1}) begin
                        rem <= rem - {1'b0, tw_m1};
                        off <= off + 7'd1;
                    end else begin
                        div_r   <= rem;
                        div_cnt <= '0;
                        state   <= S_DIV;
                    end
                end
                S_DIV: begin
                    div_r   <= div_trial[7] ? {div_r[5:0], 1'b0} : div_trial[6:0];
                    frac    <= {frac[FRAC_BITS-2:0], ~div_trial[7]};
                    div_cnt <= div_cnt + 4'd1;
                    if (div_cnt == 4'(FRAC_BITS - 1)) begin
                        rd_cnt <= '0;
                        state  <= S_READ;
                    end
                end
                S_READ: begin
                    rd_cnt <= rd_cnt + 2'd1;
                    if (single || rd_cnt == 2'd3)
                        state <= S_PUSH;
                end
                S_PUSH: begin
                    if (link.push) begin
                        dst_cnt <= dst_cnt + 1'b1;
                        if (last_col) begin
                            col <= '0;
                            rem <= '0;
                            off <= '0;
                            if (last_row) begin
                                state <= S_IDLE;
                            end else begin
                                row      <= row + 6'd1;
                                row_base <= row_base + SRC_STRIDE;
                                div_r    <= '0;
                                div_cnt  <= '0;
                                state    <= S_DIV;
                            end
                        end else begin
                            col   <= col + 6'd1;
                            rem   <= rem + {2'b00, sw_m1};  // next target step
                            state <= S_SUB;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // read data returns one cycle after src_rd
    always_ff @(posedge CLK) begin
        if (RST)
            rd_q <= 1'b0;
        else
            rd_q <= src_rd;
        rd_idx   <= rd_cnt;
        single_q <= single;
    end

    always_ff @(posedge CLK) begin
        if (rd_q) begin
            if (single_q) begin
                taps[0] <= tap_t'({1'b0, src_data, 1'b0});
                taps[1] <= tap_t'({1'b0, src_data, 1'b0});
                taps[2] <= tap_t'({1'b0, src_data, 1'b0});
                taps[3] <= tap_t'({1'b0, src_data, 1'b0});
            end else begin
                taps[rd_idx] <= tap_t'({1'b0, src_data, 1'b0});
            end
        end
    end

    // credit counter, a push and a returned credit may coincide
    always_ff @(posedge CLK) begin
        if (RST)
            credits <= CREDIT_W'(FIFO_DEPTH);
        else if (link.push && !link.credit)
            credits <= credits - 1'b1;
        else if (!link.push && link.credit)
            credits <= credits + 1'b1;
    end

endmodule

//--- hw/tap_fifo.sv
`timescale 1ns/1ps

module tap_fifo #(
    parameter type item_t = bic_pkg::tap_group_t
) (
    input  logic     CLK,
    input  logic     RST,
    tap_link_if.fifo link
);
    import bic_pkg::*;

    item_t               mem [FIFO_DEPTH];
    logic [PTR_W-1:0]    wr_ptr;
    logic [PTR_W-1:0]    rd_ptr;
    logic [CREDIT_W-1:0] count;
    logic                pop;

    assign link.pop_valid = (count != '0);
    assign link.pop_group = mem[rd_ptr];

    // the interpolator accepts whatever is shown
    assign pop         = link.pop_valid;
    assign link.credit = pop;

    always_ff @(posedge CLK) begin
        if (link.push)
            mem[wr_ptr] <= link.push_group;
    end

    always_ff @(posedge CLK) begin
        if (RST) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (link.push)
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({link.push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // both or neither
            endcase
        end
    end

endmodule

//--- hw/cubic_interp.sv
`timescale 1ns/1ps

module cubic_interp (
    input  logic               CLK,
    input  logic               RST,
    tap_link_if.interp         link,
    output logic               dst_we,
    output img_pkg::dst_addr_t dst_addr,
    output img_pkg::pixel_t    dst_data,
    output logic               done
);
    import img_pkg::*;
    import bic_pkg::*;

    tap_group_t               g;
    coef_t                    p0, p1, p2, p3;
    coef_t                    a, b, c, d;
    coef_t                    a_q, b_q, c_q, d_q;
    frac_t                    x_q;
    logic [2*FRAC_BITS-1:0]   x2_q;
    logic [3*FRAC_BITS-1:0]   x3_q;
    acc_t                     pa, pb, pc, pd;
    acc_t                     sum;
    acc_t                     rnd;
    acc_t                     whole;
    pixel_t                   pix;
    dst_addr_t                addr1, addr2;
    logic                     last1, last2, last3;
    logic                     v1, v2;

    assign g  = link.pop_group;
    assign p0 = coef_t'(g.p0);
    assign p1 = coef_t'(g.p1);
    assign p2 = coef_t'(g.p2);
    assign p3 = coef_t'(g.p3);

    // catmull-rom terms, taps are even so the halvings are exact
    assign a = p1 + (p1 >>> 1) + (p3 >>> 1) - (p0 >>> 1) - p2 - (p2 >>> 1);
    assign b = (p2 <<< 1) + p0 - (((p1 <<< 2) + p1) >>> 1) - (p3 >>> 1);
    assign c = (p2 >>> 1) - (p0 >>> 1);
    assign d = p1;

    // stage 1: coefficients and powers of x
    always_ff @(posedge CLK) begin
        a_q   <= a;
        b_q   <= b;
        c_q   <= c;
        d_q   <= d;
        x_q   <= g.frac;
        x2_q  <= g.frac * g.frac;           // 30 fraction bits
        x3_q  <= g.frac * g.frac * g.frac;  // 45 fraction bits
        addr1 <= g.addr;
        last1 <= g.last;
    end

    // stage 2: products, all aligned to 45 bits of x
    always_ff @(posedge CLK) begin
        pa    <= a_q * $signed({1'b0, x3_q});
        pb    <= (b_q * $signed({1'b0, x2_q})) <<< FRAC_BITS;
        pc    <= (c_q * $signed({1'b0, x_q})) <<< (2 * FRAC_BITS);
        pd    <= acc_t'(d_q) <<< (3 * FRAC_BITS);
        addr2 <= addr1;
        last2 <= last1;
    end

    // stage 3: sum, round half up, clamp
    assign sum   = pa + pb + pc + pd;
    assign rnd   = sum + (acc_t'(1) <<< (ACC_FRAC - 1));
    assign whole = rnd >>> ACC_FRAC;

    always_comb begin
        if (sum[ACC_W-1])
            pix = '0;                 // undershoot
        else if (whole > acc_t'(255))
            pix = 8'hff;              // overshoot saturates
        else
            pix = pixel_t'(whole);
    end

    always_ff @(posedge CLK) begin
        dst_addr <= addr2;
        dst_data <= pix;
        last3    <= last2;
    end

    always_ff @(posedge CLK) begin
        if (RST) begin
            v1     <= 1'b0;
            v2     <= 1'b0;
            dst_we <= 1'b0;
            done   <= 1'b0;
        end else begin
            v1     <= link.pop_valid;
            v2     <= v1;
            dst_we <= v2;
            done   <= dst_we && last3;  // cycle after the final write
        end
    end

endmodule

//--- hw/bicubic_scaler.sv
`timescale 1ns/1ps

module bicubic_scaler (
    input  logic               CLK,
    input  logic               RST,
    input  logic               start,
    input  img_pkg::coord_t    v0,
    input  img_pkg::coord_t    h0,
    input  logic [4:0]         sw,
    input  img_pkg::tgt_t      sh,
    input  img_pkg::tgt_t      tw,
    input  img_pkg::pixel_t    src_data,
    output logic               src_rd,
    output img_pkg::src_addr_t src_addr,
    output logic               dst_we,
    output img_pkg::dst_addr_t dst_addr,
    output img_pkg::pixel_t    dst_data,
    output logic               done
);
    import bic_pkg::*;

    tap_link_if link ();

    // producer: positions, fraction and tap reads
    tap_fetcher fetcher_inst (
        .CLK      (CLK),
        .RST      (RST),
        .start    (start),
        .v0       (v0),
        .h0       (h0),
        .sw       (sw),
        .sh       (sh),
        .tw       (tw),
        .src_rd   (src_rd),
        .src_addr (src_addr),
        .src_data (src_data),
        .link     (link)
    );

    tap_fifo #(
        .item_t (tap_group_t)
    ) fifo_inst (
        .CLK  (CLK),
        .RST  (RST),
        .link (link)
    );

    // consumer: kernel pipeline and result write
    cubic_interp interp_inst (
        .CLK      (CLK),
        .RST      (RST),
        .link     (link),
        .dst_we   (dst_we),
        .dst_addr (dst_addr),
        .dst_data (dst_data),
        .done     (done)
    );

endmodule

//--- tb/scaler_properties.sv
`timescale 1ns/1ps

module scaler_properties (
    input logic                          CLK,
    input logic                          RST,
    input logic                          push,
    input logic                          pop,
    input logic [bic_pkg::CREDIT_W-1:0]  fifo_count,
    input logic [bic_pkg::CREDIT_W-1:0]  credits,
    input logic                          dst_we,
    input logic                          done
);
    import bic_pkg::*;

    int fail_cnt = 0;   // failed assertion count

    // credits plus stored entries stay at the depth, so full means no credit left
    a_no_push_full: assert property (@(posedge CLK) disable iff (RST)
        push |-> fifo_count != CREDIT_W'(FIFO_DEPTH))
        else begin
            $error("tap fifo pushed while full");
            fail_cnt++;
        end

    a_credit_bound: assert property (@(posedge CLK) disable iff (RST)
        credits <= CREDIT_W'(FIFO_DEPTH))
        else begin
            $error("credit count above fifo depth");
            fail_cnt++;
        end

    a_done_pulse: assert property (@(posedge CLK) disable iff (RST)
        done |=> !done)
        else begin
            $error("done held longer than one cycle");
            fail_cnt++;
        end

    // fixed three-stage kernel pipeline
    a_pop_to_write: assert property (@(posedge CLK) disable iff (RST)
        pop |-> ##3 dst_we)
        else begin
            $error("no result write three cycles after a pop");
            fail_cnt++;
        end

    a_write_from_pop: assert property (@(posedge CLK) disable iff (RST)
        dst_we |-> $past(pop, 3))
        else begin
            $error("result write without a pop three cycles earlier");
            fail_cnt++;
        end

endmodule

bind bicubic_scaler scaler_properties props_inst (
    .CLK        (CLK),
    .RST        (RST),
    .push       (link.push),
    .pop        (link.pop_valid),
    .fifo_count (fifo_inst.count),
    .credits    (fetcher_inst.credits),
    .dst_we     (dst_we),
    .done       (done)
);

//--- tb/tb_bicubic_scaler.sv
`timescale 1ns/1ps

module tb_bicubic_scaler;
    import img_pkg::*;
    import bic_pkg::*;

    localparam int TOTAL_PIXELS    = 600;   // tw*sh summed over all runs
    localparam int WATCHDOG_CYCLES = TOTAL_PIXELS * 40 + 2000;
    localparam int SRC_SIZE        = 100 * 100;
    localparam int FILL_RANDOM     = 0;
    localparam int FILL_FLAT       = 1;
    localparam int FILL_STEPS      = 2;

    logic        CLK;
    logic        RST;
    logic        start;
    coord_t      v0;
    coord_t      h0;
    logic [4:0]  sw;
    tgt_t        sh;
    tgt_t        tw;
    pixel_t      src_data;
    logic        src_rd;
    src_addr_t   src_addr;
    logic        dst_we;
    dst_addr_t   dst_addr;
    pixel_t      dst_data;
    logic        done;

    pixel_t      src_mem [SRC_SIZE];
    pixel_t      res_mem [4096];
    int          wr_cnt  [4096];
    int          exp_val [4096];
    logic [31:0] lfsr;
    logic        rd_pend;
    src_addr_t   rd_addr;
    int          total_wr;
    int          done_cnt;
    int          wr_at_done;
    int          tests_run;
    int          tests_failed;
    int          err_total;

    bicubic_scaler bicubic_scaler_inst (.*);

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge CLK);
        $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("CHECKS FAILED");
        $finish;
    end

    // memory models and done monitor on the falling edge
    always @(negedge CLK) begin
        if (rd_pend)
            src_data = src_mem[rd_addr];
        rd_pend = src_rd;
        rd_addr = src_addr;
        if (dst_we) begin
            res_mem[dst_addr] = dst_data;
            wr_cnt[dst_addr]++;
            total_wr++;
        end
        if (done) begin
            done_cnt++;
            wr_at_done = total_wr;
        end
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic pixel_t random_pixel();
        pixel_t p = '0;
        for (int i = 0; i < 8; i++) begin
            lfsr = lfsr_next(lfsr);
            p = {p[6:0], lfsr[0]};
        end
        return p;
    endfunction

    task automatic fill_source(input int kind);
        for (int a = 0; a < SRC_SIZE; a++) begin
            case (kind)
                FILL_RANDOM: src_mem[a] = random_pixel();
                FILL_FLAT:   src_mem[a] = 8'd173;
                default:     src_mem[a] = ((a / 5) % 2) ? 8'd255 : 8'd0;  // 0/255 steps
            endcase
        end
    endtask

    // catmull-rom kernel on half-unit taps with x scaled by 2^15
    function automatic int kernel_value(int q0, int q1, int q2, int q3, longint x);
        longint s0, s1, s2, s3;
        longint a, b, c, d;
        longint acc;
        longint whole;
        s0 = 2 * q0;
        s1 = 2 * q1;
        s2 = 2 * q2;
        s3 = 2 * q3;
        a = (s1 - s2) + ((s1 - s2) >>> 1) + ((s3 - s0) >>> 1);
        b = 2 * s2 + s0 - 2 * s1 - (s1 >>> 1) - (s3 >>> 1);
        c = (s2 - s0) >>> 1;
        d = s1;
        acc = a * x * x * x + ((b * x * x) <<< FRAC_BITS)
            + ((c * x) <<< (2 * FRAC_BITS)) + (d <<< (3 * FRAC_BITS));
        if (acc < 0)
            return 0;
        whole = (acc + (64'sd1 <<< (3 * FRAC_BITS))) >>> (3 * FRAC_BITS + 1);
        return (whole > 255) ? 255 : int'(whole);
    endfunction

    task automatic build_expected(input int rv0, rh0, rsw, rsh, rtw);
        int rem;
        int off;
        int base;
        int frac;
        int q [4];
        for (int r = 0; r < rsh; r++) begin
            rem = 0;
            off = 0;
            base = (rv0 + r) * int'(SRC_STRIDE) + rh0;
            for (int c = 0; c < rtw; c++) begin
                frac = (rem << FRAC_BITS) / (rtw - 1);
                for (int k = 0; k < 4; k++)
                    q[k] = int'(src_mem[(frac == 0) ? base + off : base + off - 1 + k]);
                exp_val[r * rtw + c] = kernel_value(q[0], q[1], q[2], q[3], longint'(frac));
                rem += rsw - 1;
                while (rem >= rtw - 1) begin
                    rem -= rtw - 1;
                    off++;
                end
            end
        end
    endtask

    task automatic run_scaler(input string name, input int rv0, rh0, rsw, rsh, rtw);
        int n;
        int errs;
        n = rsh * rtw;
        errs = 0;
        build_expected(rv0, rh0, rsw, rsh, rtw);
        for (int i = 0; i < 4096; i++)
            wr_cnt[i] = 0;
        total_wr = 0;
        done_cnt = 0;
        wr_at_done = 0;
        @(negedge CLK);
        v0 = coord_t'(rv0);
        h0 = coord_t'(rh0);
        sw = 5'(rsw);
        sh = tgt_t'(rsh);
        tw = tgt_t'(rtw);
        start = 1'b1;
        @(negedge CLK);
        start = 1'b0;
        while (done_cnt == 0)
            @(negedge CLK);
        repeat (4) @(negedge CLK);  // late writes or a second done show up here
        for (int i = 0; i < n; i++) begin
            if (wr_cnt[i] != 1) begin
                $display("FAIL %0t: %s address %0d written %0d times", $time, name, i, wr_cnt[i]);
                errs++;
            end else if (int'(res_mem[i]) != exp_val[i]) begin
                $display("FAIL %0t: %s address %0d got %0d expected %0d",
                         $time, name, i, res_mem[i], exp_val[i]);
                errs++;
            end
        end
        if (total_wr != n) begin
            $display("FAIL %0t: %s saw %0d writes, expected %0d", $time, name, total_wr, n);
            errs++;
        end
        if (done_cnt != 1 || wr_at_done != n) begin
            $display("FAIL %0t: %s done pulsed %0d times, after %0d of %0d writes",
                     $time, name, done_cnt, wr_at_done, n);
            errs++;
        end
        tests_run++;
        if (errs != 0)
            tests_failed++;
        err_total += errs;
        $display("%s: %0d pixels, %0d errors", name, n, errs);
    endtask

    initial begin
        RST = 1'b1;
        start = 1'b0;
        v0 = '0;
        h0 = '0;
        sw = '0;
        sh = '0;
        tw = '0;
        src_data = '0;
        rd_pend = 1'b0;
        rd_addr = '0;
        lfsr = 32'h3263f23f;
        total_wr = 0;
        done_cnt = 0;
        wr_at_done = 0;
        tests_run = 0;
        tests_failed = 0;
        err_total = 0;
        repeat (5) @(posedge CLK);
        @(negedge CLK);
        RST = 1'b0;

        fill_source(FILL_RANDOM);
        run_scaler("identity", 5, 10, 10, 3, 10);
        run_scaler("upscale", 20, 30, 9, 4, 32);
        fill_source(FILL_FLAT);
        run_scaler("flat image", 40, 50, 7, 2, 20);
        fill_source(FILL_STEPS);
        run_scaler("step edges", 60, 20, 12, 3, 40);
        fill_source(FILL_RANDOM);
        run_scaler("back to back a", 0, 1, 25, 2, 16);  // downscale
        run_scaler("back to back b", 90, 60, 17, 10, 25);

        $display("%0d tests run, %0d failed, %0d errors, %0d assertion failures",
                 tests_run, tests_failed, err_total,
                 bicubic_scaler_inst.props_inst.fail_cnt);
        if (tests_failed == 0 && bicubic_scaler_inst.props_inst.fail_cnt == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

//--- bicubic_scaler.f
hw/img_pkg.sv
hw/bic_pkg.sv
hw/tap_link_if.sv
hw/tap_fetcher.sv
hw/tap_fifo.sv
hw/cubic_interp.sv
hw/bicubic_scaler.sv
tb/scaler_properties.sv
tb/tb_bicubic_scaler.sv
